//--- build.f
+incdir+logic
logic/mvm_isa_pkg.sv
logic/mvm_data_pkg.sv
logic/mvm_ifs.sv
logic/stream_fifo.sv
logic/rx_steer.sv
logic/inst_store.sv
logic/issue_ctrl.sv
logic/dot_engine.sv
logic/mvm_tile.sv
testbench/tb_mvm_tile.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mvm_tile -f build.f -o sim_mvm_tile

./obj_dir/sim_mvm_tile | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"

//--- testbench/tb_mvm_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module tb_clock #(
    parameter int HALF_NS = 5
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end
endmodule

module tb_mvm_tile;
    localparam int LIMIT = 5000;   // Cycles allowed for any single wait

    logic        clk;
    logic        rst;
    logic        rx_tvalid, rx_tready, tx_tvalid, tx_tready;
    logic [31:0] rx_tdata, rx_tuser, tx_tdata, tx_tuser;
    logic [3:0]  tx_tdest;

    logic [31:0] rf_model [`MVM_DPES][`MVM_RF_DEPTH];
    int          acc_model [`MVM_DPES];
    logic [31:0] prog [$];
    logic [31:0] red_model [$];
    logic [67:0] exp_q [$];      // {tdest, tuser, tdata}
    logic [67:0] exp_word;
    int          prog_ptr = 0;
    int          errors = 0;
    int          checks = 0;
    int          received = 0;
    int          produced = 0;   // Pushes into the output queue since reset
    int          taken = 0;      // Transmit handshakes since reset
    int          bp_left = 0;
    logic        bp_en = 1'b0;

    tb_clock u_clk (.clk (clk));

    mvm_tile DUT (
        .clk (clk), .rst (rst),
        .i_rx_tvalid (rx_tvalid), .i_rx_tdata (rx_tdata), .i_rx_tuser (rx_tuser),
        .o_rx_tready (rx_tready),
        .o_tx_tvalid (tx_tvalid), .o_tx_tdata (tx_tdata), .o_tx_tdest (tx_tdest),
        .o_tx_tuser (tx_tuser), .i_tx_tready (tx_tready)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic end_run();
        $display("Checks %0d, errors %0d, results received %0d", checks, errors, received);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("Timeout after %0d cycles while waiting for %s", LIMIT, what);
        end_run();
    endtask

    function automatic logic [31:0] make_inst(input logic op, input logic [3:0] dest,
            input logic [5:0] raddr, input logic last, input logic rel,
            input logic acc, input logic red);
        return {op, dest, raddr, 17'd0, last, rel, acc, red};
    endfunction

    // Receive tuser: mask 14:11, op 10:9, row 5:0
    function automatic logic [31:0] make_tuser(input logic [1:0] op, input logic [3:0] mask,
            input logic [5:0] addr);
        return {17'd0, mask, op, 3'd0, addr};
    endfunction

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic send_word(input logic [31:0] data, input logic [31:0] user);
        int waited;
        waited = 0;
        rx_tvalid = 1'b1;
        rx_tdata  = data;
        rx_tuser  = user;
        #1;
        while (!rx_tready && waited < LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        @(negedge clk);
        rx_tvalid = 1'b0;
        if (waited >= LIMIT) timeout_abort("rx_tready");
    endtask

    task automatic write_row(input logic [3:0] mask, input logic [5:0] addr,
                             input logic [31:0] data);
        for (int e = 0; e < `MVM_DPES; e++) begin
            if (mask[e]) rf_model[e][addr] = data;
        end
        send_word(data, make_tuser(2'd3, mask, addr));
    endtask

    task automatic send_program();
        foreach (prog[i]) send_word(prog[i], make_tuser(2'd0, 4'd0, 6'd0));
        prog_ptr = 0;
    endtask

    // One issued instruction, applied to every engine
    task automatic model_inst(input logic [31:0] inst, input logic [31:0] vec);
        logic [31:0]       red;
        logic [31:0]       row;
        logic [31:0]       word;
        logic signed [7:0] a;
        logic signed [7:0] b;
        int                sum;
        red  = '0;
        word = '0;
        if (inst[0]) red = red_model.pop_front();
        for (int e = 0; e < `MVM_DPES; e++) begin
            row = rf_model[e][inst[26:21]];
            sum = inst[1] ? acc_model[e] : 0;
            for (int l = 0; l < `MVM_LANES; l++) begin
                a = row[8*l +: 8];
                b = vec[8*l +: 8];
                sum += int'(a) * int'(b);
            end
            b = red[8*e +: 8];
            if (inst[0]) sum += int'(b);
            if (inst[2]) begin
                word[8*e +: 8] = sum[7:0];
                acc_model[e] = 0;
            end else begin
                acc_model[e] = sum;
            end
        end
        if (inst[2]) exp_q.push_back({inst[30:27], (inst[31] ? 32'd2 : 32'd1) << 9, word});
    endtask

    // Runs the program up to its next last instruction on one input vector
    task automatic send_input(input logic [31:0] vec);
        int          p;
        int          nred;
        logic [31:0] inst;
        logic [31:0] rv;
        p    = prog_ptr;
        nred = 0;
        do begin
            inst = prog[p];
            p = (p + 1) % prog.size();
            nred += inst[0];
        end while (!inst[3]);
        for (int i = 0; i < nred; i++) begin   // Reduction vectors go in ahead of the input
            rv = $urandom;
            red_model.push_back(rv);
            send_word(rv, make_tuser(2'd1, 4'd0, 6'd0));
        end
        do begin
            inst = prog[prog_ptr];
            prog_ptr = (prog_ptr + 1) % prog.size();
            model_inst(inst, vec);
        end while (!inst[3]);
        send_word(vec, make_tuser(2'd2, 4'd0, 6'd0));
    endtask

    task automatic random_program(input int len);
        logic fin;
        for (int i = 0; i < len; i++) begin
            fin = (i == len - 1);
            prog.push_back(make_inst(1'($urandom_range(1, 0)), 4'($urandom_range(15, 0)),
                6'($urandom_range(63, 0)), fin, fin | 1'($urandom_range(1, 0)),
                1'($urandom_range(1, 0)), 1'($urandom_range(1, 0))));
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        prog.delete();
        red_model.delete();
        prog_ptr = 0;
        foreach (acc_model[e]) acc_model[e] = 0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bp_en  = 1'b0;
        while (exp_q.size() != 0 && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= LIMIT) timeout_abort("expected transmit words");
        repeat (20) @(negedge clk);   // Any stray word shows up here
        check_value("o_tx_tvalid", tx_tvalid, 32'd0);
    endtask

    // Transmit ready, with random stalls when back-pressure is on
    initial begin
        forever begin
            @(negedge clk);
            if (bp_en && bp_left > 0) begin
                tx_tready = 1'b0;
                bp_left--;
            end else if (bp_en && $urandom_range(7, 0) == 0) begin
                tx_tready = 1'b0;
                bp_left   = $urandom_range(40, 4);
            end else begin
                tx_tready = 1'b1;
            end
        end
    end

    // Outputs are sampled mid low phase, stable until the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            #2;
            if (rst) begin
                produced = 0;
                taken    = 0;
            end else begin
                if (!rx_tvalid) check_value("o_rx_tready", rx_tready, 32'd0);
                if (DUT.eng_valid[0]) produced++;
                if (tx_tvalid && tx_tready) begin
                    taken++;
                    received++;
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Transmit word 0x%h arrived with no result expected", tx_tdata);
                    end else begin
                        exp_word = exp_q.pop_front();
                        check_value("o_tx_tdata", tx_tdata, exp_word[31:0]);
                        check_value("o_tx_tuser", tx_tuser, exp_word[63:32]);
                        check_value("o_tx_tdest", 32'(tx_tdest), 32'(exp_word[67:64]));
                    end
                end
                assert (produced - taken <= `MVM_OUT_DEPTH) else begin
                    errors++;
                    $display("Output queue holds %0d results, more than its depth",
                             produced - taken);
                end
            end
        end
    end

    initial begin
        void'($urandom(86819));
        rst       = 1'b1;
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        rx_tuser  = '0;
        tx_tready = 1'b0;
        @(negedge clk);
        apply_reset();

        // Idle outputs straight after reset
        check_value("o_tx_tvalid", tx_tvalid, 32'd0);
        check_value("o_rx_tready", rx_tready, 32'd0);

        // Every row of every engine gets a known value, then masked rewrites
        for (int r = 0; r < `MVM_RF_DEPTH; r++) write_row(4'hf, 6'(r), $urandom);
        repeat (24) write_row(4'($urandom_range(15, 0)), 6'($urandom_range(63, 0)), $urandom);
        prog.push_back(make_inst(1'($urandom_range(1, 0)), 4'($urandom_range(15, 0)),
                                 6'($urandom_range(63, 0)), 1'b1, 1'b1, 1'b0, 1'b0));
        send_program();
        repeat (3) send_input($urandom);
        drain();

        // Three chunks summed into one result
        apply_reset();
        for (int c = 0; c < 3; c++) begin
            prog.push_back(make_inst(1'b1, 4'(c + 5), 6'($urandom_range(63, 0)),
                                     c == 2, c == 2, 1'b1, 1'b0));
        end
        send_program();
        repeat (4) send_input($urandom);
        drain();

        // Two reduction vectors per pass
        apply_reset();
        prog.push_back(make_inst(1'b0, 4'd0, 6'd11, 1'b0, 1'b0, 1'b1, 1'b1));
        prog.push_back(make_inst(1'b0, 4'd9, 6'd42, 1'b1, 1'b1, 1'b1, 1'b1));
        send_program();
        repeat (4) send_input($urandom);
        drain();

        apply_reset();
        random_program(5);
        send_program();
        repeat (40) send_input($urandom);
        drain();

        // Same again under transmit stalls
        apply_reset();
        random_program(4);
        send_program();
        bp_en = 1'b1;
        repeat (60) send_input($urandom);
        drain();

        end_run();
    end

endmodule

`default_nettype wire

//--- logic/mvm_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module mvm_tile (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_rx_tvalid,
    input  wire  [`MVM_DATAW-1:0]    i_rx_tdata,
    input  wire  [`MVM_DATAW-1:0]    i_rx_tuser,
    output logic                     o_rx_tready,
    output logic                     o_tx_tvalid,
    output logic [`MVM_DATAW-1:0]    o_tx_tdata,
    output logic [`MVM_NODESW-1:0]   o_tx_tdest,
    output logic [`MVM_DATAW-1:0]    o_tx_tuser,
    input  wire                      i_tx_tready
);
    logic                     inst_push, reduce_push, input_push, loading;
    logic                     inst_full, reduce_full, input_full;
    logic                     inst_empty, reduce_empty, input_empty, out_empty;
    logic                     inst_pop, reduce_pop, input_pop;
    logic [`MVM_DATAW-1:0]    rx_wdata;
    logic [`MVM_DPES-1:0]     rf_wen;
    logic [`MVM_RF_ADDRW-1:0] rf_waddr;
    mvm_isa_pkg::inst_t       inst;
    mvm_data_pkg::vec_t       input_vec, reduce_vec;
    logic [`MVM_DPES-1:0]     eng_valid;
    logic                     tx_op, tx_fire;

    issue_if  iss ();
    result_if res ();

    rx_steer u_rx (
        .clk (clk), .rst (rst),
        .i_rx_tvalid (i_rx_tvalid), .i_rx_tdata (i_rx_tdata), .i_rx_tuser (i_rx_tuser),
        .o_rx_tready (o_rx_tready),
        .i_inst_full (inst_full), .i_reduce_full (reduce_full), .i_input_full (input_full),
        .o_inst_push (inst_push), .o_reduce_push (reduce_push), .o_input_push (input_push),
        .o_wdata (rx_wdata), .o_rf_wen (rf_wen), .o_rf_waddr (rf_waddr),
        .o_loading (loading)
    );

    inst_store u_prog (
        .clk (clk), .rst (rst),
        .i_push (inst_push), .i_wdata (rx_wdata), .i_loading (loading), .i_pop (inst_pop),
        .o_inst (inst), .o_empty (inst_empty), .o_full (inst_full)
    );

    stream_fifo #(.WIDTH (`MVM_DATAW), .DEPTH (`MVM_FIFO_DEPTH)) u_input_q (
        .clk (clk), .rst (rst),
        .i_push (input_push), .i_data (rx_wdata), .i_pop (input_pop),
        .o_data (input_vec), .o_empty (input_empty), .o_full (input_full)
    );

    stream_fifo #(.WIDTH (`MVM_DATAW), .DEPTH (`MVM_FIFO_DEPTH)) u_reduce_q (
        .clk (clk), .rst (rst),
        .i_push (reduce_push), .i_data (rx_wdata), .i_pop (reduce_pop),
        .o_data (reduce_vec), .o_empty (reduce_empty), .o_full (reduce_full)
    );

    issue_ctrl u_issue (
        .clk (clk), .rst (rst),
        .i_inst (inst), .i_inst_empty (inst_empty), .i_input_empty (input_empty),
        .i_reduce_empty (reduce_empty), .i_input_vec (input_vec), .i_reduce_vec (reduce_vec),
        .i_credit_return (tx_fire),
        .o_inst_pop (inst_pop), .o_input_pop (input_pop), .o_reduce_pop (reduce_pop),
        .iss (iss.src), .o_rel_dest (res.dest), .o_rel_op (res.op)
    );

    for (genvar g = 0; g < `MVM_DPES; g++) begin : g_eng
        dot_engine #(.IDX (g)) u_eng (
            .clk (clk), .rst (rst), .iss (iss.snk),
            .i_rf_wen (rf_wen[g]), .i_rf_waddr (rf_waddr), .i_rf_wdata (rx_wdata),
            .o_valid (eng_valid[g]), .o_result (res.result[g])
        );
    end

    assign res.valid = eng_valid[0];   // Engines run in lockstep

    // Sized by the credit count, so it never overflows
    stream_fifo #(.WIDTH (1 + `MVM_NODESW + `MVM_DATAW), .DEPTH (`MVM_OUT_DEPTH)) u_out_q (
        .clk (clk), .rst (rst),
        .i_push (res.valid), .i_data ({res.op, res.dest, res.result}), .i_pop (tx_fire),
        .o_data ({tx_op, o_tx_tdest, o_tx_tdata}), .o_empty (out_empty), .o_full ()
    );

    assign o_tx_tvalid = !out_empty;
    assign tx_fire     = o_tx_tvalid && i_tx_tready;
    assign o_tx_tuser  = {{(`MVM_DATAW - 11){1'b0}},
                          tx_op ? mvm_isa_pkg::TX_OP_INPUT : mvm_isa_pkg::TX_OP_REDUCE,
                          9'b0};

endmodule

`default_nettype wire

//--- logic/dot_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module dot_engine #(
    parameter int IDX = 0   // Byte of the reduction vector for this engine
) (
    input  wire                       clk,
    input  wire                       rst,
    issue_if.snk                      iss,
    input  wire                       i_rf_wen,
    input  wire  [`MVM_RF_ADDRW-1:0]  i_rf_waddr,
    input  wire  mvm_data_pkg::vec_t  i_rf_wdata,
    output logic                      o_valid,
    output mvm_data_pkg::lane_t       o_result
);
    mvm_data_pkg::vec_t rf [`MVM_RF_DEPTH];
    mvm_data_pkg::vec_t row;
    mvm_data_pkg::acc_t acc;
    mvm_data_pkg::acc_t dot;
    mvm_data_pkg::acc_t sum;

    always_ff @(posedge clk) begin
        if (i_rf_wen) begin
            rf[i_rf_waddr] <= i_rf_wdata;
        end
    end

    assign row = rf[iss.rf_raddr];

    // Signed four-lane product, widened before the multiply
    always_comb begin
        dot = '0;
        for (int l = 0; l < `MVM_LANES; l++) begin
            dot += mvm_data_pkg::acc_t'($signed(row[l])) *
                   mvm_data_pkg::acc_t'($signed(iss.in_vec[l]));
        end
    end

    always_comb begin
        sum = dot;
        if (iss.accum_en) begin
            sum += acc;
        end
        if (iss.reduce) begin
            sum += mvm_data_pkg::acc_t'($signed(iss.red_vec[IDX]));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= iss.valid && iss.release_en;
            if (iss.valid) begin
                acc <= iss.release_en ? '0 : sum;   // Release starts a fresh sum
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss.valid && iss.release_en) begin
            o_result <= sum[`MVM_PREC-1:0];   // Low byte only
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module issue_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  mvm_isa_pkg::inst_t  i_inst,
    input  wire                       i_inst_empty,
    input  wire                       i_input_empty,
    input  wire                       i_reduce_empty,
    input  wire  mvm_data_pkg::vec_t  i_input_vec,
    input  wire  mvm_data_pkg::vec_t  i_reduce_vec,
    input  wire                       i_credit_return,
    output logic                      o_inst_pop,
    output logic                      o_input_pop,
    output logic                      o_reduce_pop,
    issue_if.src                      iss,
    output logic [`MVM_NODESW-1:0]    o_rel_dest,
    output logic                      o_rel_op
);
    localparam int CREDW = $clog2(`MVM_OUT_DEPTH + 1);

    logic [CREDW-1:0]         credits;
    logic                     spend;
    logic                     s1_valid;
    logic                     s1_accum_en;
    logic                     s1_reduce;
    logic                     s1_release;
    logic [`MVM_RF_ADDRW-1:0] s1_raddr;
    mvm_data_pkg::vec_t       s1_in_vec;
    mvm_data_pkg::vec_t       s1_red_vec;
    logic [`MVM_NODESW:0]     rel_pipe [`MVM_ISSUE_LAT];   // {op, dest}

    assign o_inst_pop = !i_inst_empty && !i_input_empty &&
                        (!i_inst.reduce || !i_reduce_empty) &&
                        (!i_inst.release_en || credits != '0);
    assign o_input_pop  = o_inst_pop && i_inst.last;   // Vector done after its last chunk
    assign o_reduce_pop = o_inst_pop && i_inst.reduce;
    assign spend        = o_inst_pop && i_inst.release_en;

    // One credit per free slot in the output queue
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDW'(`MVM_OUT_DEPTH);
        end else begin
            credits <= credits - CREDW'(spend) + CREDW'(i_credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            iss.valid <= 1'b0;
        end else begin
            s1_valid  <= o_inst_pop;
            iss.valid <= s1_valid;
        end
    end

    // Operand stages
    always_ff @(posedge clk) begin
        s1_accum_en    <= i_inst.accum_en;
        s1_reduce      <= i_inst.reduce;
        s1_release     <= i_inst.release_en;
        s1_raddr       <= i_inst.rf_raddr;
        s1_in_vec      <= i_input_vec;
        s1_red_vec     <= i_reduce_vec;
        iss.accum_en   <= s1_accum_en;
        iss.reduce     <= s1_reduce;
        iss.release_en <= s1_release;
        iss.rf_raddr   <= s1_raddr;
        iss.in_vec     <= s1_in_vec;
        iss.red_vec    <= s1_red_vec;
    end

    // Release tag, in step with the engine outputs
    always_ff @(posedge clk) begin
        rel_pipe[0] <= {i_inst.release_op, i_inst.release_dest};
        for (int i = 1; i < `MVM_ISSUE_LAT; i++) begin
            rel_pipe[i] <= rel_pipe[i-1];
        end
    end

    assign {o_rel_op, o_rel_dest} = rel_pipe[`MVM_ISSUE_LAT-1];

    // Returns come from transmit handshakes on entries bought with credits
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CREDW'(`MVM_OUT_DEPTH));

endmodule

`default_nettype wire

//--- logic/inst_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module inst_store (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_push,
    input  wire  mvm_isa_pkg::inst_t i_wdata,
    input  wire                      i_loading,
    input  wire                      i_pop,
    output mvm_isa_pkg::inst_t       o_inst,
    output logic                     o_empty,
    output logic                     o_full
);
    logic               push;
    mvm_isa_pkg::inst_t wdata;

    // Outside loading the popped head goes back in at the tail
    assign push  = i_loading ? i_push : i_pop;
    assign wdata = i_loading ? i_wdata : o_inst;

    stream_fifo #(
        .WIDTH (`MVM_DATAW),
        .DEPTH (`MVM_INST_DEPTH)
    ) u_prog (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_data  (wdata),
        .i_pop   (i_pop),
        .o_data  (o_inst),
        .o_empty (o_empty),
        .o_full  (o_full)
    );

    // Instruction words from the stream only arrive while loading is flagged
    a_push_while_loading: assert property (@(posedge clk) disable iff (rst)
        i_push |-> i_loading);

endmodule

`default_nettype wire

//--- logic/rx_steer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

module rx_steer (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           i_rx_tvalid,
    input  wire  [`MVM_DATAW-1:0]         i_rx_tdata,
    input  wire  mvm_isa_pkg::tuser_t     i_rx_tuser,
    output logic                          o_rx_tready,
    input  wire                           i_inst_full,
    input  wire                           i_reduce_full,
    input  wire                           i_input_full,
    output logic                          o_inst_push,
    output logic                          o_reduce_push,
    output logic                          o_input_push,
    output logic [`MVM_DATAW-1:0]         o_wdata,
    output logic [`MVM_DPES-1:0]          o_rf_wen,
    output logic [`MVM_RF_ADDRW-1:0]      o_rf_waddr,
    output logic                          o_loading
);
    logic room;
    logic accept;

    // Room in the target of this word
    always_comb begin
        case (i_rx_tuser.op)
            mvm_isa_pkg::OP_INST:   room = !i_inst_full;
            mvm_isa_pkg::OP_REDUCE: room = !i_reduce_full;
            mvm_isa_pkg::OP_INPUT:  room = !i_input_full;
            default:                room = 1'b1;   // RF rows never wait
        endcase
    end

    assign o_rx_tready = i_rx_tvalid && room;
    assign accept      = o_rx_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_inst_push   <= 1'b0;
            o_reduce_push <= 1'b0;
            o_input_push  <= 1'b0;
            o_rf_wen      <= '0;
            o_loading     <= 1'b0;
        end else begin
            o_inst_push   <= accept && i_rx_tuser.op == mvm_isa_pkg::OP_INST;
            o_reduce_push <= accept && i_rx_tuser.op == mvm_isa_pkg::OP_REDUCE;
            o_input_push  <= accept && i_rx_tuser.op == mvm_isa_pkg::OP_INPUT;
            o_rf_wen      <= (accept && i_rx_tuser.op == mvm_isa_pkg::OP_RF) ?
                             i_rx_tuser.rf_wmask : '0;
            if (accept) begin
                o_loading <= (i_rx_tuser.op == mvm_isa_pkg::OP_INST);
            end
        end
    end

    // One data bus serves all targets
    always_ff @(posedge clk) begin
        if (accept) begin
            o_wdata    <= i_rx_tdata;
            o_rf_waddr <= i_rx_tuser.rf_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_push,
    input  wire  [WIDTH-1:0] i_data,
    input  wire              i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             at_cap;

    assign at_cap  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);
    assign o_data  = mem[rd_ptr];   // Head word, read without a cycle of delay
    // A write landing this cycle that fills the last slot counts as full already
    assign o_full  = at_cap || (count == CW'(DEPTH - 1) && i_push && !i_pop);

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(i_push) - CW'(i_pop);
        end
    end

    // Writers must honour o_full, readers o_empty
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        i_push |-> !at_cap || i_pop);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- logic/mvm_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvm_macros.svh"

// Operands of one issued instruction, broadcast to every engine
interface issue_if;
    logic                     valid;
    mvm_data_pkg::vec_t       in_vec;
    mvm_data_pkg::vec_t       red_vec;
    logic [`MVM_RF_ADDRW-1:0] rf_raddr;
    logic                     accum_en;
    logic                     reduce;
    logic                     release_en;

    modport src (output valid, in_vec, red_vec, rf_raddr, accum_en, reduce, release_en);
    modport snk (input valid, in_vec, red_vec, rf_raddr, accum_en, reduce, release_en);
endinterface

// One released result on its way into the output queue
interface result_if;
    logic                   valid;
    logic [`MVM_NODESW-1:0] dest;
    logic                   op;
    mvm_data_pkg::result_t  result;

    modport src (output valid, dest, op, result);
    modport snk (input valid, dest, op, result);
endinterface

`default_nettype wire

//--- logic/mvm_data_pkg.sv
`default_nettype none

`include "mvm_macros.svh"

package mvm_data_pkg;

    // One signed lane of a vector word
    typedef logic signed [`MVM_PREC-1:0] lane_t;

    typedef lane_t [`MVM_LANES-1:0] vec_t;

    // Running sum kept by each engine
    typedef logic signed [`MVM_DATAW-1:0] acc_t;

    // Packed output word, one byte per engine
    typedef lane_t [`MVM_DPES-1:0] result_t;

endpackage

`default_nettype wire

//--- logic/mvm_isa_pkg.sv
`default_nettype none

`include "mvm_macros.svh"

package mvm_isa_pkg;

    // Kind of word on the receive stream
    typedef enum logic [1:0] {
        OP_INST   = 2'd0,
        OP_REDUCE = 2'd1,
        OP_INPUT  = 2'd2,
        OP_RF     = 2'd3
    } rx_op_e;

    typedef struct packed {
        logic [16:0]              rsvd;
        logic [`MVM_DPES-1:0]     rf_wmask;   // Engines that take an RF row
        rx_op_e                   op;
        logic [2:0]               pad;
        logic [`MVM_RF_ADDRW-1:0] rf_addr;
    } tuser_t;

    typedef struct packed {
        logic                     release_op;   // Selects the transmit op tag
        logic [`MVM_NODESW-1:0]   release_dest;
        logic [`MVM_RF_ADDRW-1:0] rf_raddr;
        logic [16:0]              unused;
        logic                     last;         // Final chunk of this input vector
        logic                     release_en;
        logic                     accum_en;
        logic                     reduce;
    } inst_t;

    // Op tags placed on the transmit tuser
    localparam logic [1:0] TX_OP_INPUT  = 2'd2;
    localparam logic [1:0] TX_OP_REDUCE = 2'd1;

endpackage

`default_nettype wire

//--- logic/mvm_macros.svh
`ifndef MVM_MACROS_SVH
`define MVM_MACROS_SVH

// Stream word and lane geometry
`define MVM_DATAW       32
`define MVM_LANES       4
`define MVM_PREC        8

// Engine array and register files
`define MVM_DPES        4
`define MVM_RF_DEPTH    64
`define MVM_RF_ADDRW    6

`define MVM_NODESW      4   // NoC destination id

// Queue depths
`define MVM_FIFO_DEPTH  16
`define MVM_INST_DEPTH  16
`define MVM_OUT_DEPTH   8   // Also the credit count after reset

// Issue to output push
`define MVM_ISSUE_LAT   3

`endif
